// ==== common/mult_defs.svh ====
`ifndef MULT_DEFS_SVH
`define MULT_DEFS_SVH

// ##################################################
// operand and product sizing
// ##################################################

`define MULT_OPERAND_WIDTH 8 // reduction tree is wired for 8 only

// ##################################################
// transport sizing
// ##################################################

`define MULT_TAG_WIDTH 4
`define MULT_FIFO_DEPTH 4 // power of two, pointers wrap

`endif

// ==== common/mult_pkg.sv ====
`default_nettype none

`include "mult_defs.svh"

package mult_pkg;

    // single multiplier input word
    typedef logic [`MULT_OPERAND_WIDTH-1:0] operand_t;

    typedef struct packed {
        operand_t a; // gates the partial product rows
        operand_t b; // row contents
    } operand_pair_t;

    // full width unsigned result
    typedef logic [2*`MULT_OPERAND_WIDTH-1:0] product_t;

endpackage

`default_nettype wire

// ==== common/link_pkg.sv ====
`default_nettype none

`include "mult_defs.svh"

package link_pkg;

    import mult_pkg::*;

    typedef logic [`MULT_TAG_WIDTH-1:0] tag_t;

    // word on the input link and in the buffer
    typedef struct packed {
        tag_t          tag;
        operand_pair_t ops;
    } job_t;

    typedef struct packed {
        tag_t     tag;     // copied from the job
        product_t product;
    } result_t;

endpackage

`default_nettype wire

// ==== multiplier/cla_adder.sv ====
`default_nettype none
`timescale 1ns/1ps

module cla_adder #(
    parameter int width = 4
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic             cin,
    output logic [width-1:0] sum,
    output logic             cout
);

    logic [width-1:0] g; // generate
    logic [width-1:0] p; // propagate
    logic [width:0]   c; // c[i] is the carry into bit i

    assign g = a & b;
    assign p = a ^ b;

    assign c[0] = cin;

    // chained lookahead, c(i+1) = g(i) | p(i) & c(i)
    for (genvar i = 0; i < width; i++) begin : g_carry
        assign c[i+1] = g[i] | (p[i] & c[i]);
    end

    assign sum  = p ^ c[width-1:0];
    assign cout = c[width];

endmodule

`default_nettype wire

// ==== multiplier/dadda_multiplier_8x8.sv ====
`default_nettype none
`timescale 1ns/1ps

module dadda_multiplier_8x8
    import mult_pkg::*;
(
    input  operand_pair_t operands,
    output product_t      product
);

    logic [7:0][7:0] pp; // pp[i][j] has weight i+j
    logic [3:0] s1, s2, s3, s4, s5, s6, s7, s9, s10, s11;
    logic [1:0] s8;
    logic c1, c2, c3, c4, c5, c6, c7, c8, c9, c10, c11;
    logic [13:0] s_final;
    logic c_final;

    for (genvar i = 0; i < 8; i++) begin : g_pp
        assign pp[i] = operands.b & {8{operands.a[i]}};
    end

    // ##################################################
    // stage 1, columns 5 to 11
    // ##################################################
    cla_adder #(.width(4)) ks_1 (
        .a({pp[1][7], pp[0][7], pp[0][6], pp[0][5]}),
        .b({pp[2][6], pp[1][6], pp[1][5], pp[1][4]}),
        .cin(1'b0), .sum(s1), .cout(c1)
    );
    cla_adder #(.width(4)) ks_2 (
        .a({pp[2][7], pp[3][5], pp[2][5], pp[2][4]}),
        .b({pp[3][6], pp[4][4], pp[3][4], pp[3][3]}),
        .cin(1'b0), .sum(s2), .cout(c2)
    );
    cla_adder #(.width(4)) ks_3 (
        .a({pp[3][7], pp[4][5], pp[5][3], pp[4][3]}),
        .b({pp[4][6], pp[5][4], pp[6][2], pp[5][2]}),
        .cin(1'b0), .sum(s3), .cout(c3)
    );

    // ##################################################
    // stage 2
    // ##################################################
    cla_adder #(.width(4)) ks_4 (
        .a({pp[4][2], pp[2][3], pp[0][4], pp[0][3]}),
        .b({pp[5][1], pp[3][2], pp[1][3], pp[1][2]}),
        .cin(1'b0), .sum(s4), .cout(c4)
    );
    cla_adder #(.width(4)) ks_5 (
        .a({pp[6][1], pp[6][0], pp[4][1], pp[2][2]}),
        .b({pp[7][0], s1[1], pp[5][0], pp[3][1]}),
        .cin(1'b0), .sum(s5), .cout(c5)
    );
    cla_adder #(.width(4)) ks_6 (
        .a({pp[5][5], pp[6][3], pp[7][1], s2[1]}),
        .b({pp[6][4], pp[7][2], 1'b0, s3[0]}),
        .cin(s1[2]), .sum(s6), .cout(c6) // s1[2] enters as carry at weight 7
    );
    cla_adder #(.width(4)) ks_7 (
        .a({pp[4][7], pp[7][3], c1, s2[2]}),
        .b({pp[5][6], c2, s2[3], s3[1]}),
        .cin(s1[3]), .sum(s7), .cout(c7)
    );
    cla_adder #(.width(2)) ks_8 (
        .a({pp[5][7], pp[7][4]}),
        .b({pp[6][6], c3}),
        .cin(pp[6][5]), .sum(s8), .cout(c8)
    );

    // ##################################################
    // stage 3
    // ##################################################
    cla_adder #(.width(4)) ks_9 (
        .a({s1[0], pp[4][0], pp[2][1], pp[0][2]}),
        .b({s4[2], s4[1], pp[3][0], pp[1][1]}),
        .cin(1'b0), .sum(s9), .cout(c9)
    );
    cla_adder #(.width(4)) ks_10 (
        .a({s3[2], c5, c4, s4[3]}),
        .b({s6[2], s6[1], s5[3], s5[2]}),
        .cin(s2[0]), .sum(s10), .cout(c10)
    );
    cla_adder #(.width(4)) ks_11 (
        .a({pp[6][7], pp[7][5], c6, s6[3]}),
        .b({pp[7][6], c7, s7[3], s7[2]}),
        .cin(s3[3]), .sum(s11), .cout(c11)
    );

    // last two rows, weights 1 to 14
    cla_adder #(.width(14)) ks_final (
        .a({pp[7][7], c8, s8[1], s8[0], c10, s7[1], s7[0],
            s6[0], c9, s5[1], s5[0], s4[0], pp[2][0], pp[0][1]}),
        .b({c11, s11[3], s11[2], s11[1], s11[0], s10[3], s10[2],
            s10[1], s10[0], s9[3], s9[2], s9[1], s9[0], pp[1][0]}),
        .cin(1'b0), .sum(s_final), .cout(c_final)
    );

    assign product = {c_final, s_final, pp[0][0]}; // bit 0 needs no adder

endmodule

`default_nettype wire

// ==== rtl/operand_intake.sv ====
`default_nettype none
`timescale 1ns/1ps

module operand_intake
    import link_pkg::*;
(
    input  logic clk,
    input  logic rst,

    // input link
    input  logic in_req,
    output logic in_ack,
    input  job_t in_job,

    // buffer side
    output logic push,
    output job_t push_job,
    input  logic full
);

    typedef enum logic {
        st_idle,
        st_acked
    } state_t;

    state_t state;

    // ##################################################
    // handshake controller
    // ##################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (in_req && !full) begin
                        state <= st_acked; // job is written at this edge
                    end
                end
                st_acked: begin
                    if (!in_req) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // one push per four-phase cycle
    assign push = (state == st_idle) && in_req && !full;
    assign in_ack = (state == st_acked);

    assign push_job = in_job; // held stable by the sender while in_req is high

endmodule

`default_nettype wire

// ==== rtl/job_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mult_defs.svh"

module job_fifo
    import link_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  job_t push_job,
    input  logic pop,
    output job_t pop_job,
    output logic full,
    output logic empty
);

    localparam int depth = `MULT_FIFO_DEPTH;
    localparam int ptr_width = $clog2(depth);
    localparam logic [ptr_width:0] full_count = (ptr_width+1)'(depth);

    job_t mem [depth];

    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width:0]   count;
    logic [ptr_width:0]   count_next;

    always_comb begin
        count_next = count;
        case ({push, pop})
            2'b10: count_next = count + 1'b1;
            2'b01: count_next = count - 1'b1;
            default: ;  // both or neither
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count_next;
            full  <= (count_next == full_count);
            empty <= (count_next == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_job;
        end
    end

    assign pop_job = mem[rd_ptr]; // head entry

endmodule

`default_nettype wire

// ==== rtl/product_sender.sv ====
`default_nettype none
`timescale 1ns/1ps

module product_sender
    import mult_pkg::*;
    import link_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // buffer side
    output logic    pop,
    input  job_t    pop_job,
    input  logic    empty,

    // result link
    output logic    out_req,
    input  logic    out_ack,
    output result_t out_result
);

    product_t head_product;

    // ##################################################
    // arithmetic on the head entry
    // ##################################################

    dadda_multiplier_8x8 u_mult (
        .operands(pop_job.ops),
        .product (head_product)
    );

    // ##################################################
    // output four-phase link
    // ##################################################

    // link idle means req low and the previous ack already returned low
    assign pop = !empty && !out_req && !out_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_req <= 1'b0;
        end else begin
            if (pop) begin
                out_req <= 1'b1;
            end else if (out_req && out_ack) begin
                out_req <= 1'b0;
            end
        end
    end

    // payload only moves on a pop, so it holds while out_req is high
    always_ff @(posedge clk) begin
        if (pop) begin
            out_result.tag     <= pop_job.tag;
            out_result.product <= head_product;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mult_stream_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module mult_stream_top
    import link_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    in_req,
    output logic    in_ack,
    input  job_t    in_job,
    output logic    out_req,
    input  logic    out_ack,
    output result_t out_result
);

    logic push;
    logic pop;
    logic full;
    logic empty;
    job_t push_job;
    job_t pop_job;

    operand_intake u_intake (
        .clk     (clk),
        .rst     (rst),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .in_job  (in_job),
        .push    (push),
        .push_job(push_job),
        .full    (full)
    );

    job_fifo u_fifo (
        .clk     (clk),
        .rst     (rst),
        .push    (push),
        .push_job(push_job),
        .pop     (pop),
        .pop_job (pop_job),
        .full    (full),
        .empty   (empty)
    );

    product_sender u_sender (
        .clk       (clk),
        .rst       (rst),
        .pop       (pop),
        .pop_job   (pop_job),
        .empty     (empty),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_result(out_result)
    );

endmodule

`default_nettype wire

// ==== verification/mult_stream_sva.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mult_defs.svh"

module mult_stream_sva
    import link_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    in_ack,
    input logic    out_req,
    input logic    out_ack,
    input result_t out_result,
    input logic    push,
    input logic    pop
);

    int fail_count = 0;
    int level; // entries held, counted from push and pop traffic

    // ##################################################
    // buffer rules
    // ##################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            level <= 0;
        end else begin
            level <= level + int'(push) - int'(pop);
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        !(push && level == `MULT_FIFO_DEPTH))
    else begin
        $error("push while buffer full");
        fail_count++;
    end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        !(pop && level == 0))
    else begin
        $error("pop while buffer empty");
        fail_count++;
    end

    // ##################################################
    // link rules
    // ##################################################

    result_stable: assert property (@(posedge clk) disable iff (rst)
        (out_req && !out_ack) |=> $stable(out_result))
    else begin
        $error("out_result moved before out_ack");
        fail_count++;
    end

    quiet_in_reset: assert property (@(posedge clk) rst |=> (!in_ack && !out_req))
    else begin
        $error("handshake output high during reset");
        fail_count++;
    end

endmodule

bind mult_stream_top mult_stream_sva u_sva (
    .clk(clk), .rst(rst), .in_ack(in_ack), .out_req(out_req), .out_ack(out_ack),
    .out_result(out_result), .push(push), .pop(pop)
);

`default_nettype wire

// ==== verification/mult_stream_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mult_defs.svh"

module mult_stream_tb
    import mult_pkg::*;
    import link_pkg::*;
();

    localparam int n_random = 200;
    localparam int n_corner = 26;
    localparam int n_backpressure = `MULT_FIFO_DEPTH + 2;
    localparam int n_protocol = 30;
    localparam int n_jobs = n_random + n_corner + n_backpressure + n_protocol;
    localparam int cycle_limit = n_jobs * 20 + 200;

    logic    clk = 1'b0;
    logic    rst;
    logic    in_req;
    logic    in_ack;
    job_t    in_job;
    logic    out_req;
    logic    out_ack;
    result_t out_result;

    int      seed = 32'ha826;
    int      errors = 0;
    int      test_errors = 0;
    int      tests_passed = 0;
    int      tests_failed = 0;
    int      cycles = 0;
    logic    hold_ack = 1'b0; // responder withholds out_ack while set
    string   test_name = "none";
    result_t expect_q[$];     // results still owed, oldest first

    mult_stream_top u_mult_stream_top (.*);

    always #20 clk = ~clk;

    // ##################################################
    // compare tasks and reference model
    // ##################################################

    task automatic check_product(input string name, input product_t exp, input product_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_tag(input string name, input tag_t exp, input tag_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    function automatic result_t expected_result(input job_t j);
        result_t r;
        r.tag = j.tag;
        r.product = product_t'(j.ops.a) * product_t'(j.ops.b);
        return r;
    endfunction

    function automatic job_t make_job(input int tag, input int a, input int b);
        job_t j;
        j.tag = tag_t'(tag);
        j.ops.a = operand_t'(a);
        j.ops.b = operand_t'(b);
        return j;
    endfunction

    function automatic job_t random_job();
        return make_job($random(seed), $random(seed), $random(seed));
    endfunction

    // ##################################################
    // input link driver
    // ##################################################

    task automatic offer_job(input job_t j);
        in_job <= j;
        in_req <= 1'b1;
    endtask

    task automatic finish_handshake(input job_t j);
        @(negedge clk);
        while (!in_ack) @(negedge clk);
        expect_q.push_back(expected_result(j)); // accepted, so a result is owed
        @(posedge clk);
        in_req <= 1'b0;
        @(negedge clk);
        while (in_ack) @(negedge clk);
    endtask

    task automatic send_job(input job_t j);
        @(posedge clk);
        offer_job(j);
        finish_handshake(j);
    endtask

    task automatic wait_drain();
        @(negedge clk);
        while (expect_q.size() != 0 || out_req || out_ack) @(negedge clk);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        if (errors == test_errors) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    // ##################################################
    // result link responder
    // ##################################################

    initial begin : responder
        result_t held;
        result_t exp;
        int delay;
        out_ack <= 1'b0;
        forever begin
            @(negedge clk);
            if (out_req === 1'b1) begin
                held = out_result;
                if (expect_q.size() == 0) begin
                    $display("result with tag %h arrived with no job owed in %s", held.tag,
                             test_name);
                    errors++;
                end else begin
                    exp = expect_q.pop_front();
                    check_tag({test_name, " tag"}, exp.tag, held.tag);
                    check_product({test_name, " product"}, exp.product, held.product);
                end
                delay = $unsigned($random(seed)) % 8;
                while (delay > 0 || hold_ack) begin
                    @(negedge clk);
                    check_flag({test_name, " out_req held"}, 1'b1, out_req);
                    check_tag({test_name, " tag held"}, held.tag, out_result.tag);
                    check_product({test_name, " product held"}, held.product, out_result.product);
                    if (delay > 0) delay--;
                end
                @(posedge clk);
                out_ack <= 1'b1;
                @(negedge clk);
                while (out_req) @(negedge clk);
                delay = $unsigned($random(seed)) % 4; // ack stays high a little longer
                repeat (delay) begin
                    @(negedge clk);
                    check_flag({test_name, " no request before ack falls"}, 1'b0, out_req);
                end
                @(posedge clk);
                out_ack <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout, the run went past %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    // ##################################################
    // test sequence
    // ##################################################

    initial begin : main
        job_t j;
        rst <= 1'b1;
        in_req <= 1'b0;
        in_job <= '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        start_test("reset_state");
        repeat (20) begin
            @(negedge clk);
            check_flag("reset_state in_ack", 1'b0, in_ack);
            check_flag("reset_state out_req", 1'b0, out_req);
        end
        finish_test();

        start_test("random_products");
        repeat (n_random) send_job(random_job());
        wait_drain();
        finish_test();

        start_test("corner_operands");
        for (int i = 0; i < 8; i++) begin
            send_job(make_job(i, 1 << i, 1 << i));
            send_job(make_job(i + 8, 1 << i, 'hff));
        end
        send_job(make_job(0, 0, 0));
        send_job(make_job(1, 0, 'hff));
        send_job(make_job(2, 'hff, 0));
        send_job(make_job(3, 1, 1));
        send_job(make_job(4, 1, 'hff));
        send_job(make_job(5, 'hff, 'hff)); // top carry
        send_job(make_job(6, 'haa, 'h55));
        send_job(make_job(7, 'h55, 'haa));
        send_job(make_job(8, 'haa, 'haa));
        send_job(make_job(9, 'h55, 'h55));
        wait_drain();
        finish_test();

        start_test("back_pressure");
        @(posedge clk);
        hold_ack = 1'b1;
        repeat (`MULT_FIFO_DEPTH + 1) send_job(random_job()); // one in the sender, rest buffered
        j = random_job();
        @(posedge clk);
        offer_job(j);
        repeat (20) begin
            @(negedge clk);
            check_flag("back_pressure extra job held off", 1'b0, in_ack);
        end
        @(posedge clk);
        hold_ack = 1'b0;
        finish_handshake(j);
        wait_drain();
        finish_test();

        start_test("output_protocol");
        repeat (n_protocol) send_job(random_job());
        wait_drain();
        finish_test();

        $display("test count: passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0 && u_mult_stream_top.u_sva.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+common
common/mult_pkg.sv
common/link_pkg.sv
multiplier/cla_adder.sv
multiplier/dadda_multiplier_8x8.sv
rtl/operand_intake.sv
rtl/job_fifo.sv
rtl/product_sender.sv
rtl/mult_stream_top.sv
verification/mult_stream_sva.sv
verification/mult_stream_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mult_stream_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
